// File: icache_pkg.sv
package icache_pkg;

  // cache geometry
  localparam int line_bytes = 16;
  localparam int line_num = 16;
  localparam int words_per_line = 4;

  localparam int addr_w = 32;
  localparam int data_w = 32;

  // address field widths
  localparam int tag_w = 24;
  localparam int index_w = 4;
  localparam int word_w = $clog2(words_per_line);
  localparam int byte_w = $clog2(data_w / 8);
  localparam int offset_w = $clog2(line_bytes);

  // fetch address, seen either as cache fields or as a line number
  typedef union packed {
    struct packed {
      logic [tag_w-1:0]   tag;
      logic [index_w-1:0] index;
      logic [word_w-1:0]  word;
      logic [byte_w-1:0]  byte_off;
    } fields;
    struct packed {
      logic [addr_w-offset_w-1:0] line;
      logic [offset_w-1:0]        offset;
    } lines;
  } icache_addr_u;

  // controller states
  typedef enum logic [1:0] {
    state_idle,
    state_lookup,
    state_refill,
    state_respond
  } ctrl_state_e;

endpackage

// File: icache_fill_if.sv
`timescale 1ns/1ps

interface icache_fill_if import icache_pkg::*;;

  // refill request from the controller
  logic         start;
  icache_addr_u line_addr;

  // one strobe per beat accepted from memory
  logic              beat_valid;
  logic [word_w-1:0] beat_idx;
  logic [data_w-1:0] beat_data;

  // high with the final beat of the burst
  logic done;

  modport ctrl (
    output start,
    output line_addr,
    input  done
  );

  modport refill (
    input  start,
    input  line_addr,
    output beat_valid,
    output beat_idx,
    output beat_data,
    output done
  );

  modport store (
    input beat_valid,
    input beat_idx,
    input beat_data
  );

endinterface

// File: icache_ctrl.sv
`timescale 1ns/1ps

module icache_ctrl import icache_pkg::*; (
  input  logic               clock,
  input  logic               reset,

  // fetch side
  input  logic               fetch_valid_i,
  input  icache_addr_u       fetch_addr_i,
  output logic               fetch_ready_o,

  // lookup result from the tag store
  input  logic               hit_i,

  // registered address fields for the stores
  output logic [index_w-1:0] index_o,
  output logic [tag_w-1:0]   tag_o,
  output logic [word_w-1:0]  word_o,

  icache_fill_if.ctrl        fill
);

  ctrl_state_e  state_q;
  ctrl_state_e  state_d;
  icache_addr_u addr_q;

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q <= state_idle;
    end else begin
      state_q <= state_d;
    end
  end

  // capture the request when it is accepted in idle
  always_ff @(posedge clock) begin
    if (state_q == state_idle && fetch_valid_i) begin
      addr_q <= fetch_addr_i;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      state_idle: begin
        if (fetch_valid_i) begin
          state_d = state_lookup;
        end
      end
      state_lookup: begin
        if (hit_i) begin
          state_d = state_respond;
        end else begin
          state_d = state_refill;
        end
      end
      state_refill: begin
        // look up again once the line is in, which then hits
        if (fill.done) begin
          state_d = state_lookup;
        end
      end
      state_respond: begin
        state_d = state_idle;
      end
      default: begin
        state_d = state_idle;
      end
    endcase
  end

  // a miss in lookup kicks off the burst
  assign fill.start = (state_q == state_lookup) && !hit_i;
  assign fill.line_addr = addr_q;

  assign index_o = addr_q.fields.index;
  assign tag_o = addr_q.fields.tag;
  assign word_o = addr_q.fields.word;

  // one-cycle pulse, data is read from the store in the same cycle
  assign fetch_ready_o = (state_q == state_respond);

endmodule

// File: icache_tag_store.sv
`timescale 1ns/1ps

module icache_tag_store import icache_pkg::*; (
  input  logic               clock,
  input  logic               reset,

  // line under lookup or refill
  input  logic [index_w-1:0] index_i,
  input  logic [tag_w-1:0]   tag_i,

  // refill complete, tag_i becomes the owner of the line
  input  logic               fill_done_i,

  output logic               hit_o
);

  logic [tag_w-1:0]    tag_q [line_num];
  logic [line_num-1:0] valid_q;

  always_ff @(posedge clock) begin
    if (reset) begin
      valid_q <= '0;
      for (int i = 0; i < line_num; i++) begin
        tag_q[i] <= '0;
      end
    end else if (fill_done_i) begin
      tag_q[index_i] <= tag_i;
      valid_q[index_i] <= 1'b1;
    end
  end

  // combinational compare against the registered index
  assign hit_o = valid_q[index_i] && (tag_q[index_i] == tag_i);

endmodule

// File: icache_data_store.sv
`timescale 1ns/1ps

module icache_data_store import icache_pkg::*; (
  input  logic               clock,

  // line and word selected by the controller
  input  logic [index_w-1:0] index_i,
  input  logic [word_w-1:0]  word_i,

  // refill beats
  icache_fill_if.store       fill,

  output logic [data_w-1:0]  data_o
);

  // one entry per word of every line
  logic [data_w-1:0] data_q [line_num][words_per_line];

  // each beat lands in its own word of the line being filled
  always_ff @(posedge clock) begin
    if (fill.beat_valid) begin
      data_q[index_i][fill.beat_idx] <= fill.beat_data;
    end
  end

  // word select, valid whenever the line is present
  assign data_o = data_q[index_i][word_i];

endmodule

// File: icache_refill.sv
`timescale 1ns/1ps

module icache_refill import icache_pkg::*; (
  input  logic              clock,
  input  logic              reset,

  // memory read bus
  output logic              mem_rd_valid_o,
  output logic [addr_w-1:0] mem_rd_addr_o,
  input  logic              mem_rd_ready_i,
  input  logic [data_w-1:0] mem_rd_data_i,
  input  logic              mem_rd_last_i,

  icache_fill_if.refill     fill
);

  logic [word_w-1:0] beat_cnt_q;
  logic              accept;

  // a beat is taken on every ready strobe during the burst
  assign accept = mem_rd_valid_o && mem_rd_ready_i;

  always_ff @(posedge clock) begin
    if (reset) begin
      mem_rd_valid_o <= 1'b0;
      beat_cnt_q <= '0;
    end else if (fill.start) begin
      mem_rd_valid_o <= 1'b1;
      beat_cnt_q <= '0;
    end else if (accept) begin
      beat_cnt_q <= beat_cnt_q + 1'b1;
      // last strobe ends the burst, the count is not cross-checked here
      if (mem_rd_last_i) begin
        mem_rd_valid_o <= 1'b0;
      end
    end
  end

  // burst address is the line-aligned fetch address
  always_ff @(posedge clock) begin
    if (fill.start) begin
      mem_rd_addr_o <= {fill.line_addr.lines.line, {offset_w{1'b0}}};
    end
  end

  // forward each beat straight to the stores
  assign fill.beat_valid = accept;
  assign fill.beat_idx = beat_cnt_q;
  assign fill.beat_data = mem_rd_data_i;
  assign fill.done = accept && mem_rd_last_i;

endmodule

// File: icache_top.sv
`timescale 1ns/1ps

module icache_top import icache_pkg::*; (
  input  logic              clock,
  input  logic              reset,

  // fetch unit
  input  logic              fetch_valid_i,
  input  logic [addr_w-1:0] fetch_addr_i,
  output logic              fetch_ready_o,
  output logic [data_w-1:0] fetch_data_o,

  // memory read bus
  output logic              mem_rd_valid_o,
  output logic [addr_w-1:0] mem_rd_addr_o,
  input  logic              mem_rd_ready_i,
  input  logic [data_w-1:0] mem_rd_data_i,
  input  logic              mem_rd_last_i
);

  logic [index_w-1:0] index;
  logic [tag_w-1:0]   tag;
  logic [word_w-1:0]  word;
  logic               hit;

  icache_fill_if fill_if ();

  icache_ctrl u_ctrl (
    .clock         (clock),
    .reset         (reset),
    .fetch_valid_i (fetch_valid_i),
    .fetch_addr_i  (fetch_addr_i),
    .fetch_ready_o (fetch_ready_o),
    .hit_i         (hit),
    .index_o       (index),
    .tag_o         (tag),
    .word_o        (word),
    .fill          (fill_if.ctrl)
  );

  icache_tag_store u_tag_store (
    .clock       (clock),
    .reset       (reset),
    .index_i     (index),
    .tag_i       (tag),
    .fill_done_i (fill_if.done),
    .hit_o       (hit)
  );

  icache_data_store u_data_store (
    .clock   (clock),
    .index_i (index),
    .word_i  (word),
    .fill    (fill_if.store),
    .data_o  (fetch_data_o)
  );

  icache_refill u_refill (
    .clock          (clock),
    .reset          (reset),
    .mem_rd_valid_o (mem_rd_valid_o),
    .mem_rd_addr_o  (mem_rd_addr_o),
    .mem_rd_ready_i (mem_rd_ready_i),
    .mem_rd_data_i  (mem_rd_data_i),
    .mem_rd_last_i  (mem_rd_last_i),
    .fill           (fill_if.refill)
  );

endmodule

// File: icache_asserts.sv
`timescale 1ns/1ps

module icache_asserts import icache_pkg::*; (
  input logic              clock,
  input logic              reset,
  input logic              fetch_ready_i,
  input logic              mem_rd_valid_i,
  input logic [addr_w-1:0] mem_rd_addr_i,
  input logic              mem_rd_ready_i,
  input logic              mem_rd_last_i,
  input ctrl_state_e       state_i
);

  // response is a single-cycle pulse
  a_ready_single: assert property (@(posedge clock) disable iff (reset)
    fetch_ready_i |=> !fetch_ready_i)
    else $error("fetch_ready_o high for two cycles in a row");

  // bursts always start on a line boundary
  a_addr_aligned: assert property (@(posedge clock) disable iff (reset)
    mem_rd_valid_i |-> (mem_rd_addr_i[3:0] == 4'h0))
    else $error("mem_rd_addr_o not line aligned during a burst");

  a_valid_held: assert property (@(posedge clock) disable iff (reset)
    (mem_rd_valid_i && !(mem_rd_ready_i && mem_rd_last_i)) |=> mem_rd_valid_i)
    else $error("mem_rd_valid_o dropped before the last beat");

  a_no_ready_in_burst: assert property (@(posedge clock) disable iff (reset)
    mem_rd_valid_i |-> !fetch_ready_i)
    else $error("fetch_ready_o high during a refill burst");

  // the bus unit and the controller agree on when a burst is running
  a_burst_in_refill: assert property (@(posedge clock) disable iff (reset)
    mem_rd_valid_i |-> (state_i == state_refill))
    else $error("memory read active while the controller is not refilling");

endmodule

bind icache_top icache_asserts u_asserts (
  .clock          (clock),
  .reset          (reset),
  .fetch_ready_i  (fetch_ready_o),
  .mem_rd_valid_i (mem_rd_valid_o),
  .mem_rd_addr_i  (mem_rd_addr_o),
  .mem_rd_ready_i (mem_rd_ready_i),
  .mem_rd_last_i  (mem_rd_last_i),
  .state_i        (u_ctrl.state_q)
);

// File: icache_checker.sv
`timescale 1ns/1ps

module icache_checker import icache_pkg::*; (
  input  logic              clock,
  input  logic              reset,
  input  logic [2:0]        test_id_i,
  input  logic              fetch_valid_i,
  input  logic [addr_w-1:0] fetch_addr_i,
  input  logic              fetch_ready_i,
  input  logic [data_w-1:0] fetch_data_i,
  input  logic              mem_rd_valid_i,
  input  logic [addr_w-1:0] mem_rd_addr_i,
  input  logic              mem_rd_ready_i,
  input  logic              mem_rd_last_i,
  output int                error_count_o,
  output int                check_count_o
);

  // shadow of the direct-mapped tag array
  logic [23:0]         shadow_tag [16];
  logic [15:0]         shadow_valid;
  logic                pending;
  logic                valid_prev;
  logic [addr_w-1:0]   req_addr;
  int                  edges;
  int                  bursts;
  int                  beats;
  int                  errors = 0;
  int                  checks = 0;

  // memory contents, a scramble of the word address
  function automatic logic [data_w-1:0] mem_word(input logic [addr_w-1:0] addr);
    logic [31:0] w;
    w = {2'b00, addr[31:2]};
    return {w[18:0], w[31:19]} ^ (w * 32'h9e37_79b1);
  endfunction

  function automatic string test_name(input logic [2:0] id);
    case (id)
      3'd0: return "cold_miss";
      3'd1: return "hit";
      3'd2: return "conflict";
      3'd3: return "back_pressure";
      3'd4: return "random_stream";
      default: return "reset";
    endcase
  endfunction

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("Fail %s %s: expected %h, actual %h", test_name(test_id_i), what,
               expected, actual);
    end
  endtask

  task automatic report(input string msg);
    errors++;
    $display("error in %s: %s", test_name(test_id_i), msg);
  endtask

  always @(posedge clock) begin
    logic [3:0] idx;
    logic       miss;
    if (reset) begin
      shadow_valid = '0;
      pending = 1'b0;
      valid_prev = 1'b0;
      bursts = 0;
      beats = 0;
      edges = 0;
    end else begin
      edges++;
      if (mem_rd_valid_i && !valid_prev) begin
        bursts++;
        beats = 0;
        if (!pending) begin
          report("memory read started while no fetch was pending");
        end else begin
          check_value("burst address", {req_addr[31:4], 4'h0}, mem_rd_addr_i);
        end
      end
      valid_prev = mem_rd_valid_i;
      if (mem_rd_valid_i && mem_rd_ready_i) begin
        beats++;
        // response is timed from the last beat on a miss
        if (mem_rd_last_i) begin
          check_value("beats per burst", 32'd4, beats);
          edges = 0;
        end
      end
      if (fetch_ready_i) begin
        if (!pending) begin
          report("fetch_ready_o pulsed while no fetch was pending");
        end else begin
          idx = req_addr[7:4];
          miss = !(shadow_valid[idx] && (shadow_tag[idx] == req_addr[31:8]));
          check_value("fetch data", mem_word(req_addr), fetch_data_i);
          check_value("bursts per fetch", miss ? 32'd1 : 32'd0, bursts);
          check_value("ready latency", 32'd2, edges);
          shadow_tag[idx] = req_addr[31:8];
          shadow_valid[idx] = 1'b1;
          pending = 1'b0;
        end
      end else if (!pending && fetch_valid_i) begin
        pending = 1'b1;
        req_addr = fetch_addr_i;
        edges = 0;
        bursts = 0;
      end
    end
  end

  assign error_count_o = errors;
  assign check_count_o = checks;

endmodule

// File: tb_icache.sv
`timescale 1ns/1ps

module tb_icache import icache_pkg::*;;

  localparam int num_random = 300;
  localparam int num_fixed = 48;
  localparam int max_gap = 3;
  // lookup, four gapped beats, re-lookup, respond and request spacing
  localparam int worst_miss_cycles = 2 + words_per_line * (max_gap + 2) + 4;
  localparam int timeout_ns = (num_random + num_fixed) * worst_miss_cycles * 8 * 2;

  logic              clock = 1'b0;
  logic              reset;
  logic              fetch_valid_i;
  logic [addr_w-1:0] fetch_addr_i;
  logic              fetch_ready_o;
  logic [data_w-1:0] fetch_data_o;
  logic              mem_rd_valid_o;
  logic [addr_w-1:0] mem_rd_addr_o;
  logic              mem_rd_ready_i;
  logic [data_w-1:0] mem_rd_data_i;
  logic              mem_rd_last_i;
  logic [2:0]        test_id;
  int                error_count;
  int                check_count;
  integer            seed = 32'h2d48_32aa;
  logic [23:0]       tag_pool [3];

  always #4 clock = ~clock;

  icache_top DUT (
    .clock          (clock),
    .reset          (reset),
    .fetch_valid_i  (fetch_valid_i),
    .fetch_addr_i   (fetch_addr_i),
    .fetch_ready_o  (fetch_ready_o),
    .fetch_data_o   (fetch_data_o),
    .mem_rd_valid_o (mem_rd_valid_o),
    .mem_rd_addr_o  (mem_rd_addr_o),
    .mem_rd_ready_i (mem_rd_ready_i),
    .mem_rd_data_i  (mem_rd_data_i),
    .mem_rd_last_i  (mem_rd_last_i)
  );

  icache_checker u_checker (
    .clock          (clock),
    .reset          (reset),
    .test_id_i      (test_id),
    .fetch_valid_i  (fetch_valid_i),
    .fetch_addr_i   (fetch_addr_i),
    .fetch_ready_i  (fetch_ready_o),
    .fetch_data_i   (fetch_data_o),
    .mem_rd_valid_i (mem_rd_valid_o),
    .mem_rd_addr_i  (mem_rd_addr_o),
    .mem_rd_ready_i (mem_rd_ready_i),
    .mem_rd_last_i  (mem_rd_last_i),
    .error_count_o  (error_count),
    .check_count_o  (check_count)
  );

  // hold the request until the ready pulse, called on a falling edge
  task automatic fetch(input logic [addr_w-1:0] addr);
    @(negedge clock);
    fetch_valid_i = 1'b1;
    fetch_addr_i = addr;
    do begin
      @(negedge clock);
    end while (!fetch_ready_o);
    fetch_valid_i = 1'b0;
    // let the checker score the response before the caller moves on
    @(negedge clock);
  endtask

  // burst memory, four beats with random gaps
  initial begin : memory_model
    int gap;
    mem_rd_ready_i = 1'b0;
    mem_rd_data_i = '0;
    mem_rd_last_i = 1'b0;
    forever begin
      @(negedge clock);
      if (mem_rd_valid_o === 1'b1) begin
        for (int beat = 0; beat < words_per_line; beat++) begin
          gap = $unsigned($random(seed)) % (max_gap + 1);
          repeat (gap) @(negedge clock);
          mem_rd_ready_i = 1'b1;
          mem_rd_data_i = u_checker.mem_word(mem_rd_addr_o + 32'(beat * 4));
          mem_rd_last_i = (beat == words_per_line - 1);
          @(negedge clock);
          mem_rd_ready_i = 1'b0;
          mem_rd_last_i = 1'b0;
        end
      end
    end
  end

  initial begin : stimulus
    int          pick;
    logic [31:0] rnd;
    fetch_valid_i = 1'b0;
    fetch_addr_i = '0;
    test_id = 3'd0;
    tag_pool[0] = 24'h00_1234;
    tag_pool[1] = 24'h00_abc0;
    tag_pool[2] = 24'h7f_0e21;
    reset = 1'b1;
    repeat (2) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    // quiet period, nothing may move on the buses
    repeat (4) @(negedge clock);
    fetch(32'h0012_3454);
    test_id = 3'd1;
    for (int w = 0; w < words_per_line; w++) begin
      fetch({24'h00_1234, 4'h5, w[1:0], 2'b00});
    end
    fetch(32'h0012_3457);
    // same index 0xa, two tags
    test_id = 3'd2;
    for (int i = 0; i < 4; i++) begin
      fetch(32'h00ab_c0a8);
      fetch(32'h00de_f0a4);
    end
    test_id = 3'd3;
    for (int i = 0; i < 8; i++) begin
      fetch({24'h00_5500, i[3:0], 4'h0});
      fetch({24'h00_5500, i[3:0], 4'hc});
    end
    test_id = 3'd4;
    for (int i = 0; i < num_random; i++) begin
      pick = $unsigned($random(seed)) % 3;
      rnd = $random(seed);
      fetch({tag_pool[pick], rnd[7:0]});
    end
    // lines filled above must all miss again after reset
    test_id = 3'd5;
    @(negedge clock);
    reset = 1'b1;
    repeat (2) @(negedge clock);
    reset = 1'b0;
    for (int i = 0; i < 16; i++) begin
      fetch({tag_pool[0], i[3:0], 4'h0});
    end
    repeat (4) @(negedge clock);
    $display("checks %0d, errors %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  initial begin : watchdog
    #(timeout_ns);
    $display("timeout: the run did not finish within %0d ns", timeout_ns);
    $display("checks %0d, errors %0d", check_count, error_count);
    $display("Verification failed");
    $finish;
  end

endmodule

// File: build.f
icache_pkg.sv
icache_fill_if.sv
icache_ctrl.sv
icache_tag_store.sv
icache_data_store.sv
icache_refill.sv
icache_top.sv
icache_asserts.sv
icache_checker.sv
tb_icache.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_icache -f build.f

output=$(./obj_dir/Vtb_icache)
echo "$output"

if echo "$output" | grep -qx "Verification passed"; then
  exit 0
fi
exit 1
